//--- common/ex_cfg.svh
// Execute stage configuration
`ifndef EX_CFG_SVH
`define EX_CFG_SVH

// Data path and PC width
`define EX_XLEN 32

// PC value held in EX after reset
`define EX_PC_INIT 'h200

// Shift-add iterations per multiply
// one per multiplier bit
`define EX_MUL_CYCLES `EX_XLEN

`endif

//--- common/ex_pkg.sv
// Execute stage shared types

package ex_pkg;

  // Raw 32-bit instruction word
  typedef logic [31:0] instr_t;

  // ALU operations
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_LUI,   // pass opB through
    ALU_LINK   // return address pc+4
  } alu_op_e;

  // Branch unit operations
  // Nine values need a 4-bit code
  typedef enum logic [3:0] {
    BU_NONE,
    BU_BEQ,
    BU_BNE,
    BU_BLT,
    BU_BGE,
    BU_BLTU,
    BU_BGEU,
    BU_JAL,
    BU_JALR
  } bu_op_e;

  // Major opcodes in instruction bits [6:0]
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;

  // funct7 of the M extension
  localparam logic [6:0] F7_MULDIV  = 7'b0000001;

  // funct3 of MUL inside the M group
  localparam logic [2:0] F3_MUL     = 3'b000;

endpackage

//--- design/ex_decode.sv
// Execute stage instruction decode
`timescale 1ns/1ps
`include "ex_cfg.svh"

module ex_decode
  import ex_pkg::*;
(
  input  instr_t               id_insn_i,
  input  logic                 id_bubble_i,
  output logic                 alu_sel_o,
  output alu_op_e              alu_op_o,
  output bu_op_e               bu_op_o,
  output logic [`EX_XLEN-1:0]  bu_imm_o,
  output logic                 mul_sel_o
);

  // Instruction fields
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = id_insn_i[6:0];
  assign funct3 = id_insn_i[14:12];
  assign funct7 = id_insn_i[31:25];

  ////////////////////////////////////////////////////////////////////////////
  // Immediate for the branch unit
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    case (opcode)
      // B-type, bit 0 always zero
      OPC_BRANCH: bu_imm_o = {{(`EX_XLEN-13){id_insn_i[31]}}, id_insn_i[31], id_insn_i[7],
                              id_insn_i[30:25], id_insn_i[11:8], 1'b0};
      // J-type
      OPC_JAL:    bu_imm_o = {{(`EX_XLEN-21){id_insn_i[31]}}, id_insn_i[31],
                              id_insn_i[19:12], id_insn_i[20], id_insn_i[30:21], 1'b0};
      // I-type, used by JALR
      default:    bu_imm_o = {{(`EX_XLEN-12){id_insn_i[31]}}, id_insn_i[31:20]};
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Unit selects and operations
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    // Nothing selected by default
    alu_sel_o = 1'b0;
    alu_op_o  = ALU_ADD;
    bu_op_o   = BU_NONE;
    mul_sel_o = 1'b0;

    if (!id_bubble_i)
    begin
      case (opcode)
        OPC_OP, OPC_OP_IMM:
        begin
          if (opcode == OPC_OP && funct7 == F7_MULDIV)
          begin
            // Only MUL of the M group is present
            mul_sel_o = (funct3 == F3_MUL);
          end
          else
          begin
            alu_sel_o = 1'b1;
            case (funct3)
              // SUB only for register form with bit 30 set
              3'b000:  alu_op_o = (opcode == OPC_OP && id_insn_i[30]) ? ALU_SUB : ALU_ADD;
              3'b001:  alu_op_o = ALU_SLL;
              3'b010:  alu_op_o = ALU_SLT;
              3'b011:  alu_op_o = ALU_SLTU;
              3'b100:  alu_op_o = ALU_XOR;
              3'b101:  alu_op_o = id_insn_i[30] ? ALU_SRA : ALU_SRL;
              3'b110:  alu_op_o = ALU_OR;
              default: alu_op_o = ALU_AND;
            endcase
          end
        end

        OPC_LUI:
        begin
          // ID already put the upper immediate on opB
          alu_sel_o = 1'b1;
          alu_op_o  = ALU_LUI;
        end

        OPC_BRANCH:
        begin
          case (funct3)
            3'b000:  bu_op_o = BU_BEQ;
            3'b001:  bu_op_o = BU_BNE;
            3'b100:  bu_op_o = BU_BLT;
            3'b101:  bu_op_o = BU_BGE;
            3'b110:  bu_op_o = BU_BLTU;
            3'b111:  bu_op_o = BU_BGEU;
            default: bu_op_o = BU_NONE;
          endcase
        end

        // Jumps also write the link through the ALU
        OPC_JAL:
        begin
          alu_sel_o = 1'b1;
          alu_op_o  = ALU_LINK;
          bu_op_o   = BU_JAL;
        end

        OPC_JALR:
        begin
          alu_sel_o = 1'b1;
          alu_op_o  = ALU_LINK;
          bu_op_o   = BU_JALR;
        end

        default: ;
      endcase
    end
  end

endmodule

//--- ex_units/ex_alu.sv
// Integer ALU
`timescale 1ns/1ps
`include "ex_cfg.svh"

module ex_alu
  import ex_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 ex_stall_i,
  input  logic                 alu_sel_i,
  input  alu_op_e              alu_op_i,
  input  logic [`EX_XLEN-1:0]  id_pc_i,
  input  logic [`EX_XLEN-1:0]  opA_i,
  input  logic [`EX_XLEN-1:0]  opB_i,
  output logic [`EX_XLEN-1:0]  alu_r_o,
  output logic                 alu_bubble_o
);

  logic [`EX_XLEN-1:0] alu_nxt;
  logic [4:0]          shamt;

  // Shift amount from opB low bits
  assign shamt = opB_i[4:0];

  ////////////////////////////////////////////////////////////////////////////
  // Operation
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    case (alu_op_i)
      ALU_ADD:  alu_nxt = opA_i + opB_i;
      ALU_SUB:  alu_nxt = opA_i - opB_i;
      ALU_SLL:  alu_nxt = opA_i << shamt;
      ALU_SLT:  alu_nxt = {{(`EX_XLEN-1){1'b0}}, $signed(opA_i) < $signed(opB_i)};
      ALU_SLTU: alu_nxt = {{(`EX_XLEN-1){1'b0}}, opA_i < opB_i};
      ALU_XOR:  alu_nxt = opA_i ^ opB_i;
      ALU_SRL:  alu_nxt = opA_i >> shamt;
      // Arithmetic shift keeps the sign
      ALU_SRA:  alu_nxt = $unsigned($signed(opA_i) >>> shamt);
      ALU_OR:   alu_nxt = opA_i | opB_i;
      ALU_AND:  alu_nxt = opA_i & opB_i;
      ALU_LUI:  alu_nxt = opB_i;
      ALU_LINK: alu_nxt = id_pc_i + `EX_XLEN'(4);
      default:  alu_nxt = opA_i + opB_i;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////////////////////

  // Result, taken on the issue edge
  always_ff @(posedge clk_i)
  begin
    if (!ex_stall_i)
      alu_r_o <= alu_nxt;
  end

  // Bubble when not selected
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      alu_bubble_o <= 1'b1;
    else if (!ex_stall_i)
      alu_bubble_o <= ~alu_sel_i;
  end

endmodule

//--- ex_units/ex_branch.sv
// Branch resolution unit
`timescale 1ns/1ps
`include "ex_cfg.svh"

module ex_branch
  import ex_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 ex_stall_i,
  input  bu_op_e               bu_op_i,
  input  logic [`EX_XLEN-1:0]  bu_imm_i,
  input  logic [`EX_XLEN-1:0]  id_pc_i,
  input  logic [`EX_XLEN-1:0]  opA_i,
  input  logic [`EX_XLEN-1:0]  opB_i,
  input  logic [1:0]           bp_predict_i,
  output logic [`EX_XLEN-1:0]  bu_nxt_pc_o,
  output logic                 bu_flush_o
);

  logic                taken;
  logic [`EX_XLEN-1:0] target;

  // Outcome of the compare
  always_comb
  begin
    case (bu_op_i)
      BU_BEQ:  taken = (opA_i == opB_i);
      BU_BNE:  taken = (opA_i != opB_i);
      BU_BLT:  taken = ($signed(opA_i) <  $signed(opB_i));
      BU_BGE:  taken = ($signed(opA_i) >= $signed(opB_i));
      BU_BLTU: taken = (opA_i <  opB_i);
      BU_BGEU: taken = (opA_i >= opB_i);
      BU_JAL,
      BU_JALR: taken = 1'b1;
      default: taken = 1'b0;
    endcase
  end

  // JALR target is register relative with bit 0 dropped
  assign target = (bu_op_i == BU_JALR) ? ((opA_i + bu_imm_i) & ~`EX_XLEN'(1))
                                       : (id_pc_i + bu_imm_i);

  // Next PC, held under stall
  always_ff @(posedge clk_i)
  begin
    if (!ex_stall_i)
      bu_nxt_pc_o <= taken ? target : id_pc_i + `EX_XLEN'(4);
  end

  // Flush on a wrong prediction
  // Single pulse, also cleared while stalled
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      bu_flush_o <= 1'b0;
    else
      bu_flush_o <= !ex_stall_i && (bu_op_i != BU_NONE) && (taken ^ bp_predict_i[1]);
  end

endmodule

//--- ex_units/ex_mul.sv
// Iterative shift-add multiplier
`timescale 1ns/1ps
`include "ex_cfg.svh"

module ex_mul
(
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 ex_stall_i,
  input  logic                 mul_sel_i,
  input  logic [`EX_XLEN-1:0]  opA_i,
  input  logic [`EX_XLEN-1:0]  opB_i,
  output logic                 mul_busy_o,
  output logic [`EX_XLEN-1:0]  mul_r_o,
  output logic                 mul_bubble_o
);

  localparam int CNT_W = $clog2(`EX_MUL_CYCLES + 1);

  // Operand shift registers
  logic [`EX_XLEN-1:0] mcand;
  logic [`EX_XLEN-1:0] mplier;
  logic [CNT_W-1:0]    cnt;
  logic                issue;
  logic                last;

  // New multiply accepted on the issue edge
  assign issue = !ex_stall_i && mul_sel_i;

  // Final iteration
  assign last = mul_busy_o && (cnt == CNT_W'(1));

  ////////////////////////////////////////////////////////////////////////////
  // Data path
  ////////////////////////////////////////////////////////////////////////////

  // mul_r_o doubles as the accumulator
  // only shown once the bubble drops
  always_ff @(posedge clk_i)
  begin
    if (issue)
    begin
      mcand   <= opA_i;
      mplier  <= opB_i;
      mul_r_o <= '0;
    end
    else if (mul_busy_o)
    begin
      // Add shifted multiplicand for each set multiplier bit
      if (mplier[0])
        mul_r_o <= mul_r_o + mcand;
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      mul_busy_o   <= 1'b0;
      mul_bubble_o <= 1'b1;
      cnt          <= '0;
    end
    else if (mul_busy_o)
    begin
      // Iterates regardless of stall, busy is part of it
      cnt <= cnt - CNT_W'(1);
      if (last)
      begin
        mul_busy_o   <= 1'b0;
        mul_bubble_o <= 1'b0;
      end
    end
    else if (!ex_stall_i)
    begin
      // Issue slot, bubble until the product is ready
      mul_busy_o   <= mul_sel_i;
      mul_bubble_o <= 1'b1;
      cnt          <= CNT_W'(`EX_MUL_CYCLES);
    end
  end

endmodule

//--- design/ex_stage.sv
// Execute stage top level
`timescale 1ns/1ps
`include "ex_cfg.svh"

module ex_stage
  import ex_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_ni,

  // From ID
  input  logic [`EX_XLEN-1:0]  id_pc_i,
  input  instr_t               id_insn_i,
  input  logic                 id_bubble_i,
  input  logic [`EX_XLEN-1:0]  id_opA_i,
  input  logic [`EX_XLEN-1:0]  id_opB_i,
  input  logic                 id_userf_opA_i,
  input  logic                 id_userf_opB_i,
  input  logic                 id_bypex_opA_i,
  input  logic                 id_bypex_opB_i,
  input  logic [1:0]           id_bp_predict_i,

  // From register file
  input  logic [`EX_XLEN-1:0]  rf_srcv1_i,
  input  logic [`EX_XLEN-1:0]  rf_srcv2_i,

  // From MEM
  input  logic                 mem_stall_i,

  // To MEM and fetch
  output logic [`EX_XLEN-1:0]  ex_pc_o,
  output instr_t               ex_insn_o,
  output logic [`EX_XLEN-1:0]  ex_r_o,
  output logic                 ex_bubble_o,
  output logic                 ex_stall_o,
  output logic [`EX_XLEN-1:0]  bu_nxt_pc_o,
  output logic                 bu_flush_o
);

  // Selected operands
  logic [`EX_XLEN-1:0] opA;
  logic [`EX_XLEN-1:0] opB;

  // Decoded operations
  logic                alu_sel;
  alu_op_e             alu_op;
  bu_op_e              bu_op;
  logic [`EX_XLEN-1:0] bu_imm;
  logic                mul_sel;

  // Unit results
  logic [`EX_XLEN-1:0] alu_r;
  logic                alu_bubble;
  logic [`EX_XLEN-1:0] mul_r;
  logic                mul_bubble;
  logic                mul_busy;

  ////////////////////////////////////////////////////////////////////////////
  // Stall, PC and instruction
  ////////////////////////////////////////////////////////////////////////////

  assign ex_stall_o = mem_stall_i | mul_busy;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      ex_pc_o <= `EX_XLEN'(`EX_PC_INIT);
    else if (!ex_stall_o)
      ex_pc_o <= id_pc_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (!ex_stall_o)
      ex_insn_o <= id_insn_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Operand bypass
  ////////////////////////////////////////////////////////////////////////////

  // EX forward wins over register file
  assign opA = id_bypex_opA_i ? ex_r_o :
               id_userf_opA_i ? rf_srcv1_i : id_opA_i;
  assign opB = id_bypex_opB_i ? ex_r_o :
               id_userf_opB_i ? rf_srcv2_i : id_opB_i;

  ////////////////////////////////////////////////////////////////////////////
  // Decode and units
  ////////////////////////////////////////////////////////////////////////////

  ex_decode u_decode (
    .id_insn_i   ( id_insn_i   ),
    .id_bubble_i ( id_bubble_i ),
    .alu_sel_o   ( alu_sel     ),
    .alu_op_o    ( alu_op      ),
    .bu_op_o     ( bu_op       ),
    .bu_imm_o    ( bu_imm      ),
    .mul_sel_o   ( mul_sel     )
  );

  ex_alu u_alu (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .ex_stall_i   ( ex_stall_o ),
    .alu_sel_i    ( alu_sel    ),
    .alu_op_i     ( alu_op     ),
    .id_pc_i      ( id_pc_i    ),
    .opA_i        ( opA        ),
    .opB_i        ( opB        ),
    .alu_r_o      ( alu_r      ),
    .alu_bubble_o ( alu_bubble )
  );

  ex_branch u_branch (
    .clk_i        ( clk_i           ),
    .rst_ni       ( rst_ni          ),
    .ex_stall_i   ( ex_stall_o      ),
    .bu_op_i      ( bu_op           ),
    .bu_imm_i     ( bu_imm          ),
    .id_pc_i      ( id_pc_i         ),
    .opA_i        ( opA             ),
    .opB_i        ( opB             ),
    .bp_predict_i ( id_bp_predict_i ),
    .bu_nxt_pc_o  ( bu_nxt_pc_o     ),
    .bu_flush_o   ( bu_flush_o      )
  );

  ex_mul u_mul (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .ex_stall_i   ( ex_stall_o ),
    .mul_sel_i    ( mul_sel    ),
    .opA_i        ( opA        ),
    .opB_i        ( opB        ),
    .mul_busy_o   ( mul_busy   ),
    .mul_r_o      ( mul_r      ),
    .mul_bubble_o ( mul_bubble )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Result merge
  ////////////////////////////////////////////////////////////////////////////

  // Branch unit has no result, links come from the ALU
  assign ex_bubble_o = alu_bubble & mul_bubble;
  assign ex_r_o      = mul_bubble ? alu_r : mul_r;

endmodule

//--- verif/tb_clk_gen.sv
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clk_gen
(
  output logic clk_o,
  output logic rst_no
);

  // 10 ns period
  initial
  begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // Reset held for the first 4 rising edges
  initial
  begin
    rst_no <= 1'b0;
    repeat (4) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

//--- verif/tb_ex_stage.sv
// Execute stage testbench
`timescale 1ns/1ps
`include "ex_cfg.svh"

module tb_ex_stage
  import ex_pkg::*;
();

  // About 400 cycles of tests, generous margin
  localparam int TIMEOUT_CYCLES = 2000;

  logic                clk;
  logic                rst_n;
  logic [`EX_XLEN-1:0] id_pc;
  instr_t              id_insn;
  logic                id_bubble;
  logic [`EX_XLEN-1:0] id_op_a;
  logic [`EX_XLEN-1:0] id_op_b;
  logic                id_userf_a;
  logic                id_userf_b;
  logic                id_bypex_a;
  logic                id_bypex_b;
  logic [1:0]          id_bp_predict;
  logic [`EX_XLEN-1:0] rf_srcv1;
  logic [`EX_XLEN-1:0] rf_srcv2;
  logic                mem_stall;
  logic [`EX_XLEN-1:0] ex_pc;
  instr_t              ex_insn;
  logic [`EX_XLEN-1:0] ex_r;
  logic                ex_bubble;
  logic                ex_stall;
  logic [`EX_XLEN-1:0] bu_nxt_pc;
  logic                bu_flush;
  int                  cycles = 0;

  tb_clk_gen u_clk_gen (
    .clk_o  ( clk   ),
    .rst_no ( rst_n )
  );

  ex_stage dut0 (
    .clk_i           ( clk           ),
    .rst_ni          ( rst_n         ),
    .id_pc_i         ( id_pc         ),
    .id_insn_i       ( id_insn       ),
    .id_bubble_i     ( id_bubble     ),
    .id_opA_i        ( id_op_a       ),
    .id_opB_i        ( id_op_b       ),
    .id_userf_opA_i  ( id_userf_a    ),
    .id_userf_opB_i  ( id_userf_b    ),
    .id_bypex_opA_i  ( id_bypex_a    ),
    .id_bypex_opB_i  ( id_bypex_b    ),
    .id_bp_predict_i ( id_bp_predict ),
    .rf_srcv1_i      ( rf_srcv1      ),
    .rf_srcv2_i      ( rf_srcv2      ),
    .mem_stall_i     ( mem_stall     ),
    .ex_pc_o         ( ex_pc         ),
    .ex_insn_o       ( ex_insn       ),
    .ex_r_o          ( ex_r          ),
    .ex_bubble_o     ( ex_bubble     ),
    .ex_stall_o      ( ex_stall      ),
    .bu_nxt_pc_o     ( bu_nxt_pc     ),
    .bu_flush_o      ( bu_flush      )
  );

  // Watchdog
  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles == TIMEOUT_CYCLES)
    begin
      $display("Something failed");
      $fatal(1, "Run did not finish within %0d cycles", TIMEOUT_CYCLES);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_word(input string name, input logic [`EX_XLEN-1:0] exp_v,
                            input logic [`EX_XLEN-1:0] act_v);
    if (act_v !== exp_v)
    begin
      $display("** Error: %s expected %h, got %h", name, exp_v, act_v);
      $display("Something failed");
      $fatal(1, "Value mismatch on %s", name);
    end
  endtask

  task automatic check_pc(input string name, input logic [`EX_XLEN-1:0] exp_v,
                          input logic [`EX_XLEN-1:0] act_v);
    if (act_v !== exp_v)
    begin
      $display("** Error: %s expected %h, got %h", name, exp_v, act_v);
      $display("Something failed");
      $fatal(1, "PC mismatch on %s", name);
    end
  endtask

  task automatic check_bit(input string name, input logic exp_v, input logic act_v);
    if (act_v !== exp_v)
    begin
      $display("** Error: %s expected %h, got %h", name, exp_v, act_v);
      $display("Something failed");
      $fatal(1, "Flag mismatch on %s", name);
    end
  endtask

  task automatic check_insn(input string name, input instr_t exp_v, input instr_t act_v);
    if (act_v !== exp_v)
    begin
      $display("** Error: %s expected %h, got %h", name, exp_v, act_v);
      $display("Something failed");
      $fatal(1, "Instruction mismatch on %s", name);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Encoders and reference model
  ////////////////////////////////////////////////////////////////////////////

  // R-type, rd x1, rs1 x1, rs2 x2
  function automatic instr_t enc_r(input logic [6:0] f7, input logic [2:0] f3);
    return {f7, 5'd2, 5'd1, f3, 5'd1, OPC_OP};
  endfunction

  function automatic instr_t enc_i(input logic [6:0] opc, input logic [2:0] f3,
                                   input logic [11:0] imm);
    return {imm, 5'd1, f3, 5'd1, opc};
  endfunction

  // B-type immediate scattered around rs1 and rs2
  function automatic instr_t enc_b(input logic [2:0] f3, input logic [12:0] imm);
    return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic instr_t enc_j(input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, OPC_JAL};
  endfunction

  function automatic instr_t alu_insn(input alu_op_e op);
    case (op)
      ALU_ADD:  return enc_r(7'h00, 3'b000);
      ALU_SUB:  return enc_r(7'h20, 3'b000);
      ALU_SLL:  return enc_r(7'h00, 3'b001);
      ALU_SLT:  return enc_r(7'h00, 3'b010);
      ALU_SLTU: return enc_r(7'h00, 3'b011);
      ALU_XOR:  return enc_r(7'h00, 3'b100);
      ALU_SRL:  return enc_r(7'h00, 3'b101);
      ALU_SRA:  return enc_r(7'h20, 3'b101);
      ALU_OR:   return enc_r(7'h00, 3'b110);
      ALU_AND:  return enc_r(7'h00, 3'b111);
      default:  return {20'h12345, 5'd1, OPC_LUI};
    endcase
  endfunction

  function automatic logic [2:0] br_funct3(input bu_op_e op);
    case (op)
      BU_BEQ:  return 3'b000;
      BU_BNE:  return 3'b001;
      BU_BLT:  return 3'b100;
      BU_BGE:  return 3'b101;
      BU_BLTU: return 3'b110;
      default: return 3'b111;
    endcase
  endfunction

  function automatic logic [`EX_XLEN-1:0] alu_model(input alu_op_e op,
                                                    input logic [`EX_XLEN-1:0] a,
                                                    input logic [`EX_XLEN-1:0] b);
    logic [4:0]          sh;
    logic [`EX_XLEN-1:0] fill;
    sh   = b[4:0];
    // Sign bits shifted in from the top
    fill = a[`EX_XLEN-1] ? ~({`EX_XLEN{1'b1}} >> sh) : '0;
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a + ~b + 1;
      ALU_SLL:  return a << sh;
      // Differing signs decide alone
      ALU_SLT:  return (a[`EX_XLEN-1] != b[`EX_XLEN-1]) ? `EX_XLEN'(a[`EX_XLEN-1])
                                                       : `EX_XLEN'(a < b);
      ALU_SLTU: return `EX_XLEN'(a < b);
      ALU_XOR:  return a ^ b;
      ALU_SRL:  return a >> sh;
      ALU_SRA:  return (a >> sh) | fill;
      ALU_OR:   return a | b;
      ALU_AND:  return a & b;
      default:  return b;
    endcase
  endfunction

  function automatic logic branch_taken(input bu_op_e op, input logic [`EX_XLEN-1:0] a,
                                        input logic [`EX_XLEN-1:0] b);
    logic [`EX_XLEN-1:0] sa;
    logic [`EX_XLEN-1:0] sb;
    // Signed order as unsigned order with flipped sign bits
    sa = a ^ {1'b1, {(`EX_XLEN-1){1'b0}}};
    sb = b ^ {1'b1, {(`EX_XLEN-1){1'b0}}};
    case (op)
      BU_BEQ:  return a == b;
      BU_BNE:  return a != b;
      BU_BLT:  return sa < sb;
      BU_BGE:  return !(sa < sb);
      BU_BLTU: return a < b;
      BU_BGEU: return !(a < b);
      default: return 1'b1;
    endcase
  endfunction

  function automatic logic [`EX_XLEN-1:0] mul_low(input logic [`EX_XLEN-1:0] a,
                                                  input logic [`EX_XLEN-1:0] b);
    logic [2*`EX_XLEN-1:0] p;
    p = {{`EX_XLEN{1'b0}}, a} * {{`EX_XLEN{1'b0}}, b};
    return p[`EX_XLEN-1:0];
  endfunction

  function automatic logic [`EX_XLEN-1:0] random_pc();
    logic [`EX_XLEN-1:0] r;
    r      = $urandom;
    r[1:0] = 2'b00;
    return r;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Drivers
  ////////////////////////////////////////////////////////////////////////////

  // Inputs set here are taken on the following edge
  task automatic drive_insn(input instr_t insn, input logic [`EX_XLEN-1:0] pc,
                            input logic [`EX_XLEN-1:0] a, input logic [`EX_XLEN-1:0] b,
                            input logic [1:0] pred);
    @(posedge clk);
    id_insn       <= insn;
    id_pc         <= pc;
    id_op_a       <= a;
    id_op_b       <= b;
    id_bp_predict <= pred;
    id_bubble     <= 1'b0;
    id_userf_a    <= 1'b0;
    id_userf_b    <= 1'b0;
    id_bypex_a    <= 1'b0;
    id_bypex_b    <= 1'b0;
  endtask

  task automatic drive_bubble();
    @(posedge clk);
    id_bubble <= 1'b1;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_reset();
    // Still in reset here
    @(negedge clk);
    check_pc("ex_pc_o", `EX_XLEN'(`EX_PC_INIT), ex_pc);
    check_bit("ex_bubble_o", 1'b1, ex_bubble);
    check_bit("ex_stall_o", 1'b0, ex_stall);
    check_bit("bu_flush_o", 1'b0, bu_flush);
    wait (rst_n);
    @(negedge clk);
    check_bit("ex_bubble_o", 1'b1, ex_bubble);
    check_bit("ex_stall_o", 1'b0, ex_stall);
    check_bit("bu_flush_o", 1'b0, bu_flush);
  endtask

  task automatic test_alu(input alu_op_e op);
    logic [`EX_XLEN-1:0] a;
    logic [`EX_XLEN-1:0] b;
    logic [`EX_XLEN-1:0] pc;
    a  = $urandom;
    b  = $urandom;
    pc = random_pc();
    drive_insn(alu_insn(op), pc, a, b, 2'b00);
    drive_bubble();
    @(negedge clk);
    check_word("ex_r_o", alu_model(op, a, b), ex_r);
    check_pc("ex_pc_o", pc, ex_pc);
    check_insn("ex_insn_o", alu_insn(op), ex_insn);
    check_bit("ex_bubble_o", 1'b0, ex_bubble);
  endtask

  // Back to back ADDs so each forward sees the one before
  task automatic test_bypass();
    logic [`EX_XLEN-1:0] a1;
    logic [`EX_XLEN-1:0] b1;
    logic [`EX_XLEN-1:0] b2;
    logic [`EX_XLEN-1:0] a4;
    logic [`EX_XLEN-1:0] r1;
    logic [`EX_XLEN-1:0] r2;
    logic [`EX_XLEN-1:0] r3;
    logic [`EX_XLEN-1:0] rf1;
    logic [`EX_XLEN-1:0] rf2;
    a1  = $urandom;
    b1  = $urandom;
    b2  = $urandom;
    a4  = $urandom;
    rf1 = $urandom;
    rf2 = $urandom;
    drive_insn(alu_insn(ALU_ADD), random_pc(), a1, b1, 2'b00);
    // A from EX, ID operand is junk
    drive_insn(alu_insn(ALU_ADD), random_pc(), $urandom, b2, 2'b00);
    id_bypex_a <= 1'b1;
    @(negedge clk);
    r1 = a1 + b1;
    check_word("ex_r_o", r1, ex_r);
    // Both from the register file
    drive_insn(alu_insn(ALU_ADD), random_pc(), $urandom, $urandom, 2'b00);
    id_userf_a <= 1'b1;
    id_userf_b <= 1'b1;
    rf_srcv1   <= rf1;
    rf_srcv2   <= rf2;
    @(negedge clk);
    r2 = r1 + b2;
    check_word("ex_r_o", r2, ex_r);
    // B with both selects set, EX forward has priority
    drive_insn(alu_insn(ALU_ADD), random_pc(), a4, $urandom, 2'b00);
    id_userf_b <= 1'b1;
    id_bypex_b <= 1'b1;
    @(negedge clk);
    r3 = rf1 + rf2;
    check_word("ex_r_o", r3, ex_r);
    drive_bubble();
    @(negedge clk);
    check_word("ex_r_o", a4 + r3, ex_r);
  endtask

  task automatic test_branch(input bu_op_e op, input logic [1:0] pred);
    logic [`EX_XLEN-1:0] pc;
    logic [`EX_XLEN-1:0] a;
    logic [`EX_XLEN-1:0] b;
    logic [`EX_XLEN-1:0] r;
    logic [`EX_XLEN-1:0] imm;
    logic [`EX_XLEN-1:0] sum;
    logic [`EX_XLEN-1:0] target;
    logic                taken;
    instr_t              insn;
    pc = random_pc();
    a  = $urandom;
    r  = $urandom;
    // Equal operands half of the time
    b  = r[0] ? a : $urandom;
    r  = $urandom;
    case (op)
      BU_JAL:
      begin
        imm  = {{(`EX_XLEN-21){r[20]}}, r[20:1], 1'b0};
        insn = enc_j(imm[20:0]);
      end
      BU_JALR:
      begin
        imm  = {{(`EX_XLEN-12){r[11]}}, r[11:0]};
        insn = enc_i(OPC_JALR, 3'b000, imm[11:0]);
      end
      default:
      begin
        imm  = {{(`EX_XLEN-13){r[12]}}, r[12:1], 1'b0};
        insn = enc_b(br_funct3(op), imm[12:0]);
      end
    endcase
    taken  = branch_taken(op, a, b);
    sum    = a + imm;
    target = (op == BU_JALR) ? {sum[`EX_XLEN-1:1], 1'b0} : pc + imm;
    drive_insn(insn, pc, a, b, pred);
    drive_bubble();
    @(negedge clk);
    check_pc("bu_nxt_pc_o", taken ? target : pc + 4, bu_nxt_pc);
    check_bit("bu_flush_o", taken ^ pred[1], bu_flush);
    if (op == BU_JAL || op == BU_JALR)
    begin
      check_word("ex_r_o", pc + 4, ex_r);
      check_bit("ex_bubble_o", 1'b0, ex_bubble);
    end
    else
    begin
      check_bit("ex_bubble_o", 1'b1, ex_bubble);
    end
    // Flush lasts one cycle
    @(negedge clk);
    check_bit("bu_flush_o", 1'b0, bu_flush);
  endtask

  task automatic test_mul();
    logic [`EX_XLEN-1:0] a;
    logic [`EX_XLEN-1:0] b;
    logic [`EX_XLEN-1:0] pc;
    int                  waited;
    a  = $urandom;
    b  = $urandom;
    pc = random_pc();
    drive_insn(enc_r(F7_MULDIV, F3_MUL), pc, a, b, 2'b00);
    drive_bubble();
    @(negedge clk);
    check_bit("ex_stall_o", 1'b1, ex_stall);
    check_bit("ex_bubble_o", 1'b1, ex_bubble);
    waited = 0;
    while (ex_stall)
    begin
      if (waited == 4 * `EX_MUL_CYCLES)
      begin
        $display("Something failed");
        $fatal(1, "Multiplier kept the stage stalled too long");
      end
      @(negedge clk);
      waited++;
    end
    check_word("ex_r_o", mul_low(a, b), ex_r);
    check_bit("ex_bubble_o", 1'b0, ex_bubble);
    check_pc("ex_pc_o", pc, ex_pc);
  endtask

  task automatic test_backpressure();
    logic [`EX_XLEN-1:0] a1;
    logic [`EX_XLEN-1:0] b1;
    logic [`EX_XLEN-1:0] a2;
    logic [`EX_XLEN-1:0] b2;
    logic [`EX_XLEN-1:0] pc1;
    logic [`EX_XLEN-1:0] pc2;
    int                  n;
    a1  = $urandom;
    b1  = $urandom;
    a2  = $urandom;
    b2  = $urandom;
    pc1 = random_pc();
    pc2 = random_pc();
    drive_insn(alu_insn(ALU_ADD), pc1, a1, b1, 2'b00);
    // ADD issues on this edge, MEM stalls right after
    drive_insn(alu_insn(ALU_XOR), pc2, a2, b2, 2'b00);
    mem_stall <= 1'b1;
    for (n = 0; n < 5; n++)
    begin
      @(negedge clk);
      check_bit("ex_stall_o", 1'b1, ex_stall);
      check_word("ex_r_o", a1 + b1, ex_r);
      check_pc("ex_pc_o", pc1, ex_pc);
    end
    @(posedge clk);
    mem_stall <= 1'b0;
    // XOR taken on the first free edge
    drive_bubble();
    @(negedge clk);
    check_word("ex_r_o", a2 ^ b2, ex_r);
    check_pc("ex_pc_o", pc2, ex_pc);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    int i;
    int k;
    id_pc         <= '0;
    id_insn       <= '0;
    id_bubble     <= 1'b1;
    id_op_a       <= '0;
    id_op_b       <= '0;
    id_userf_a    <= 1'b0;
    id_userf_b    <= 1'b0;
    id_bypex_a    <= 1'b0;
    id_bypex_b    <= 1'b0;
    id_bp_predict <= 2'b00;
    rf_srcv1      <= '0;
    rf_srcv2      <= '0;
    mem_stall     <= 1'b0;
    void'($urandom(32'h36fb));

    test_reset();
    for (i = int'(ALU_ADD); i <= int'(ALU_LUI); i++)
      repeat (3) test_alu(alu_op_e'(i[3:0]));
    test_bypass();
    // Both predictions for every branch kind
    for (i = int'(BU_BEQ); i <= int'(BU_JALR); i++)
    begin
      for (k = 0; k < 3; k++)
      begin
        test_branch(bu_op_e'(i[3:0]), 2'b00);
        test_branch(bu_op_e'(i[3:0]), 2'b10);
      end
    end
    repeat (4) test_mul();
    test_backpressure();

    $display("Everything OK");
    $finish;
  end

endmodule

//--- ex_stage.f
+incdir+common
common/ex_pkg.sv
design/ex_decode.sv
ex_units/ex_alu.sv
ex_units/ex_branch.sv
ex_units/ex_mul.sv
design/ex_stage.sv
verif/tb_clk_gen.sv
verif/tb_ex_stage.sv

//--- Makefile
# Execute stage simulation with Verilator

TOP := tb_ex_stage

.PHONY: help test clean

help:
	@echo "make help   show this list"
	@echo "make test   build and run the testbench, pass if run.log holds the pass line"
	@echo "make clean  remove obj_dir and run.log"

test:
	verilator --binary --timing --timescale 1ns/1ps -f ex_stage.f --top-module $(TOP)
	-./obj_dir/V$(TOP) > run.log 2>&1
	@cat run.log
	@grep -qx "Everything OK" run.log

clean:
	rm -rf obj_dir run.log
